/* hw/mem_arb_config.svh */
// memory subsystem widths, memory depth and response latency.
`ifndef MEM_ARB_CONFIG_SVH
`define MEM_ARB_CONFIG_SVH

// byte address width.
`define ADDR_W 32

// one cache line, seen as bits and as 32-bit words.
`define LINE_W 256
`define LINE_WORDS 8

// physical memory size in lines.
`define PMEM_LINES 64

// cycles from strobe start to response pulse.
`define PMEM_LATENCY 4

`endif

/* hw/mem_arb_pkg.sv */
// shared types for the cache line and the physical memory address.
`default_nettype none

`include "mem_arb_config.svh"

package mem_arb_pkg;

    ////////////////////
    // address and line types
    ////////////////////

    // line-aligned byte address.
    typedef logic [`ADDR_W-1:0] pmem_addr_t;

    // one line, flat or split into words.
    typedef union packed {
        logic [`LINE_W-1:0] bits;
        logic [`LINE_WORDS-1:0][31:0] words;
    } cache_line_u;

endpackage : mem_arb_pkg

`default_nettype wire

/* hw/arbiter_control.sv */
// grant FSM that shares physical memory between instruction and data caches.
`default_nettype none
`timescale 1ns/1ps

module arbiter_control
(
    input  logic clk,
    input  logic rst,
    input  logic mem_read_i_i,
    input  logic mem_read_d_i,
    input  logic mem_write_d_i,
    input  logic pmem_resp_i,
    output logic pmem_read_o,
    output logic pmem_write_o,
    output logic mem_resp_i_o,
    output logic mem_resp_d_o,
    output logic load_i_o,
    output logic load_d_o
);

    typedef enum logic [1:0] {
        IDLE,
        I_CACHE,
        D_CACHE
    } state_t;

    state_t state;
    state_t next_state;
    logic d_pending;

    assign d_pending = mem_read_d_i || mem_write_d_i;

    ////////////////////
    // state outputs
    ////////////////////

    always_comb
    begin
        pmem_read_o = 1'b0;
        pmem_write_o = 1'b0;
        mem_resp_i_o = 1'b0;
        mem_resp_d_o = 1'b0;
        load_i_o = 1'b0;
        load_d_o = 1'b0;
        unique case (state)
            I_CACHE:
            begin
                load_i_o = 1'b1;
                pmem_read_o = mem_read_i_i;
                mem_resp_i_o = pmem_resp_i;
            end
            D_CACHE:
            begin
                load_d_o = 1'b1;
                pmem_read_o = mem_read_d_i;
                pmem_write_o = mem_write_d_i;
                mem_resp_d_o = pmem_resp_i;
            end
            default:
            begin
                // all strobes stay low in idle.
            end
        endcase
    end

    ////////////////////
    // next state
    ////////////////////

    always_comb
    begin
        next_state = state;
        unique case (state)
            IDLE:
            begin
                // instruction read wins a tie.
                if (mem_read_i_i)
                begin
                    next_state = I_CACHE;
                end
                else if (d_pending)
                begin
                    next_state = D_CACHE;
                end
            end
            I_CACHE:
            begin
                if (pmem_resp_i)
                begin
                    next_state = d_pending ? D_CACHE : IDLE;
                end
            end
            D_CACHE:
            begin
                if (pmem_resp_i)
                begin
                    next_state = mem_read_i_i ? I_CACHE : IDLE;
                end
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    // data cache must not read and write at once.
    a_no_rd_wr: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read_o && pmem_write_o));

    // a response closes a grant that was already held.
    a_resp_i_granted: assert property (@(posedge clk) disable iff (rst)
        mem_resp_i_o |-> $past(load_i_o));

    a_resp_d_granted: assert property (@(posedge clk) disable iff (rst)
        mem_resp_d_o |-> $past(load_d_o));

endmodule : arbiter_control

`default_nettype wire

/* hw/arbiter_datapath.sv */
// steers the granted request to memory and captures returned lines per port.
`default_nettype none
`timescale 1ns/1ps

module arbiter_datapath import mem_arb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        load_i_i,
    input  logic        load_d_i,
    input  logic        mem_resp_i_i,
    input  logic        mem_resp_d_i,
    input  pmem_addr_t  mem_addr_i_i,
    input  pmem_addr_t  mem_addr_d_i,
    input  cache_line_u mem_wdata_d_i,
    input  cache_line_u pmem_rdata_i,
    output pmem_addr_t  pmem_addr_o,
    output cache_line_u pmem_wdata_o,
    output cache_line_u mem_rdata_i_o,
    output cache_line_u mem_rdata_d_o
);

    // request mux.
    always_comb
    begin
        pmem_addr_o = '0;
        pmem_wdata_o = '0;
        if (load_i_i)
        begin
            pmem_addr_o = mem_addr_i_i;
        end
        else if (load_d_i)
        begin
            pmem_addr_o = mem_addr_d_i;
            pmem_wdata_o = mem_wdata_d_i;
        end
    end

    // read lines hold until the port's next response.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_rdata_i_o <= '0;
            mem_rdata_d_o <= '0;
        end
        else
        begin
            if (mem_resp_i_i && load_i_i)
            begin
                mem_rdata_i_o <= pmem_rdata_i;
            end
            if (mem_resp_d_i && load_d_i)
            begin
                mem_rdata_d_o <= pmem_rdata_i;
            end
        end
    end

    a_load_onehot0: assert property (@(posedge clk) disable iff (rst)
        $onehot0({load_i_i, load_d_i}));

endmodule : arbiter_datapath

`default_nettype wire

/* hw/pmem_model.sv */
// line-wide physical memory with fixed latency and a pattern for unwritten lines.
`default_nettype none
`timescale 1ns/1ps

`include "mem_arb_config.svh"

module pmem_model import mem_arb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        pmem_read_i,
    input  logic        pmem_write_i,
    input  pmem_addr_t  pmem_addr_i,
    input  cache_line_u pmem_wdata_i,
    output logic        pmem_resp_o,
    output cache_line_u pmem_rdata_o
);

    localparam int OFFSET_W = $clog2(`LINE_W / 8);
    localparam int IDX_W = $clog2(`PMEM_LINES);
    localparam int CNT_W = $clog2(`PMEM_LATENCY + 1);

    cache_line_u mem [`PMEM_LINES];
    logic [`PMEM_LINES-1:0] written;
    logic [IDX_W-1:0] line_idx;
    logic [CNT_W-1:0] cnt;
    logic busy;
    logic last;
    logic strobe;
    cache_line_u pattern;

    assign strobe = pmem_read_i || pmem_write_i;
    assign line_idx = pmem_addr_i[OFFSET_W +: IDX_W];
    assign last = busy && (cnt == CNT_W'(`PMEM_LATENCY - 1));

    // word k of line n reads as n*256 + k.
    always_comb
    begin
        for (int k = 0; k < `LINE_WORDS; k++)
        begin
            pattern.words[k] = (32'(line_idx) << 8) + 32'(k);
        end
    end

    ////////////////////
    // latency counter
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            cnt <= '0;
            pmem_resp_o <= 1'b0;
        end
        else
        begin
            pmem_resp_o <= last;
            if (last)
            begin
                busy <= 1'b0;
                cnt <= '0;
            end
            else if (busy)
            begin
                cnt <= cnt + 1'b1;
            end
            else if (strobe && !pmem_resp_o)
            begin
                // strobe stays high through the pulse; a new one starts after.
                busy <= 1'b1;
                cnt <= CNT_W'(1);
            end
        end
    end

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            written <= '0;
        end
        else if (last && pmem_write_i)
        begin
            written[line_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (last)
        begin
            if (pmem_write_i)
            begin
                mem[line_idx] <= pmem_wdata_i;
            end
            pmem_rdata_o <= written[line_idx] ? mem[line_idx] : pattern;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        busy |-> $stable(pmem_addr_i));

endmodule : pmem_model

`default_nettype wire

/* hw/mem_subsys_top.sv */
// memory subsystem joining the arbiter FSM, its datapath and the memory model.
`default_nettype none
`timescale 1ns/1ps

module mem_subsys_top import mem_arb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_read_i_i,
    input  pmem_addr_t  mem_addr_i_i,
    output logic        mem_resp_i_o,
    output cache_line_u mem_rdata_i_o,
    input  logic        mem_read_d_i,
    input  logic        mem_write_d_i,
    input  pmem_addr_t  mem_addr_d_i,
    input  cache_line_u mem_wdata_d_i,
    output logic        mem_resp_d_o,
    output cache_line_u mem_rdata_d_o
);

    logic pmem_read;
    logic pmem_write;
    logic pmem_resp;
    logic load_i;
    logic load_d;
    pmem_addr_t pmem_addr;
    cache_line_u pmem_wdata;
    cache_line_u pmem_rdata;

    arbiter_control arbiter_control_i (
        .clk           (clk),
        .rst           (rst),
        .mem_read_i_i  (mem_read_i_i),
        .mem_read_d_i  (mem_read_d_i),
        .mem_write_d_i (mem_write_d_i),
        .pmem_resp_i   (pmem_resp),
        .pmem_read_o   (pmem_read),
        .pmem_write_o  (pmem_write),
        .mem_resp_i_o  (mem_resp_i_o),
        .mem_resp_d_o  (mem_resp_d_o),
        .load_i_o      (load_i),
        .load_d_o      (load_d)
    );

    arbiter_datapath arbiter_datapath_i (
        .clk           (clk),
        .rst           (rst),
        .load_i_i      (load_i),
        .load_d_i      (load_d),
        .mem_resp_i_i  (mem_resp_i_o),
        .mem_resp_d_i  (mem_resp_d_o),
        .mem_addr_i_i  (mem_addr_i_i),
        .mem_addr_d_i  (mem_addr_d_i),
        .mem_wdata_d_i (mem_wdata_d_i),
        .pmem_rdata_i  (pmem_rdata),
        .pmem_addr_o   (pmem_addr),
        .pmem_wdata_o  (pmem_wdata),
        .mem_rdata_i_o (mem_rdata_i_o),
        .mem_rdata_d_o (mem_rdata_d_o)
    );

    pmem_model pmem_model_i (
        .clk          (clk),
        .rst          (rst),
        .pmem_read_i  (pmem_read),
        .pmem_write_i (pmem_write),
        .pmem_addr_i  (pmem_addr),
        .pmem_wdata_i (pmem_wdata),
        .pmem_resp_o  (pmem_resp),
        .pmem_rdata_o (pmem_rdata)
    );

endmodule : mem_subsys_top

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// clock and reset source for the memory subsystem testbench.
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk_o,
    output logic rst_o
);

    // 8 ns period.
    initial
    begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial
    begin
        rst_o = 1'b1;
        repeat (8) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

/* testbench/mem_checker.sv */
// response checker for returned lines and grant order on both cache ports.
`default_nettype none
`timescale 1ns/1ps

`include "mem_arb_config.svh"

module mem_checker import mem_arb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        contend_i,
    input  logic        mem_resp_i_i,
    input  cache_line_u mem_rdata_i_i,
    input  logic        mem_resp_d_i,
    input  cache_line_u mem_rdata_d_i,
    output int          error_count_o
);

    cache_line_u exp_i_q[$];
    cache_line_u exp_d_q[$];
    logic chk_d_q[$];
    cache_line_u exp_d;
    logic chk_d;
    logic seen_i = 1'b0;
    logic seen_d = 1'b0;
    int cnt_i = 0;
    int cnt_d = 0;
    int errors = 0;

    assign error_count_o = errors;

    // one entry per request in issue order.
    task automatic push_expected(input logic port_d, input logic check, input cache_line_u line);
        if (port_d)
        begin
            exp_d_q.push_back(line);
            chk_d_q.push_back(check);
        end
        else
        begin
            exp_i_q.push_back(line);
        end
    endtask

    task automatic compare_line(input string name, input cache_line_u got,
                                input cache_line_u exp);
        for (int k = 0; k < `LINE_WORDS; k++)
        begin
            if (got.words[k] !== exp.words[k])
            begin
                $display("CHECK FAILED %s word %0d: expected 0x%h, got 0x%h",
                    name, k, exp.words[k], got.words[k]);
                errors++;
            end
        end
    endtask

    ////////////////////
    // response monitor
    ////////////////////

    always @(negedge clk)
    begin
        if (!rst)
        begin
            // read lines are valid the cycle after the pulse.
            if (seen_i)
            begin
                if (exp_i_q.size() == 0)
                begin
                    $display("ERROR: instruction response arrived with no request pending");
                    errors++;
                end
                else
                begin
                    compare_line("mem_rdata_i_o", mem_rdata_i_i, exp_i_q.pop_front());
                end
            end
            if (seen_d)
            begin
                if (exp_d_q.size() == 0)
                begin
                    $display("ERROR: data response arrived with no request pending");
                    errors++;
                end
                else
                begin
                    exp_d = exp_d_q.pop_front();
                    chk_d = chk_d_q.pop_front();
                    if (chk_d)
                    begin
                        compare_line("mem_rdata_d_o", mem_rdata_d_i, exp_d);
                    end
                end
            end

            // grant order while both ports keep requesting.
            if (contend_i)
            begin
                if (mem_resp_d_i && cnt_i == 0)
                begin
                    $display("ERROR: data response came before the first instruction response");
                    errors++;
                end
                if (mem_resp_i_i)
                begin
                    cnt_i++;
                end
                if (mem_resp_d_i)
                begin
                    cnt_d++;
                end
                if (cnt_i > cnt_d + 1 || cnt_d > cnt_i + 1)
                begin
                    $display("ERROR: responses did not alternate, %0d instruction vs %0d data",
                        cnt_i, cnt_d);
                    errors++;
                end
            end
            else
            begin
                cnt_i = 0;
                cnt_d = 0;
            end

            seen_i = mem_resp_i_i;
            seen_d = mem_resp_d_i;
        end
    end

endmodule : mem_checker

`default_nettype wire

/* testbench/tb_mem_subsys.sv */
// testbench top that replays the transaction file on both cache ports.
`default_nettype none
`timescale 1ns/1ps

`include "mem_arb_config.svh"

module tb_mem_subsys import mem_arb_pkg::*;
();

    localparam int TXN_COUNT = 16;
    localparam int TXN_WORDS = 18;
    localparam int TIMEOUT = 200;

    logic clk;
    logic rst;
    logic mem_read_i;
    pmem_addr_t mem_addr_i;
    logic mem_resp_i;
    cache_line_u mem_rdata_i;
    logic mem_read_d;
    logic mem_write_d;
    pmem_addr_t mem_addr_d;
    cache_line_u mem_wdata_d;
    logic mem_resp_d;
    cache_line_u mem_rdata_d;
    logic contend;
    int checker_errors;
    int latency_errors;
    int timeouts;
    logic [31:0] tdata [TXN_COUNT * TXN_WORDS];
    int conc_i[$];
    int conc_d[$];

    tb_clock_gen clock_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    mem_subsys_top mem_subsys_top_i (
        .clk           (clk),
        .rst           (rst),
        .mem_read_i_i  (mem_read_i),
        .mem_addr_i_i  (mem_addr_i),
        .mem_resp_i_o  (mem_resp_i),
        .mem_rdata_i_o (mem_rdata_i),
        .mem_read_d_i  (mem_read_d),
        .mem_write_d_i (mem_write_d),
        .mem_addr_d_i  (mem_addr_d),
        .mem_wdata_d_i (mem_wdata_d),
        .mem_resp_d_o  (mem_resp_d),
        .mem_rdata_d_o (mem_rdata_d)
    );

    mem_checker mem_checker_i (
        .clk           (clk),
        .rst           (rst),
        .contend_i     (contend),
        .mem_resp_i_i  (mem_resp_i),
        .mem_rdata_i_i (mem_rdata_i),
        .mem_resp_d_i  (mem_resp_d),
        .mem_rdata_d_i (mem_rdata_d),
        .error_count_o (checker_errors)
    );

    function automatic cache_line_u line_at(input int base);
        cache_line_u line;
        for (int k = 0; k < `LINE_WORDS; k++)
        begin
            line.words[k] = tdata[base + k];
        end
        return line;
    endfunction

    // runs one request from raise to drop starting on a falling edge.
    task automatic run_txn(input int idx, input logic timed);
        int base;
        int cycles;
        logic port_d;
        logic write;
        logic got;
        base = idx * TXN_WORDS;
        port_d = tdata[base][4];
        write = tdata[base][0];
        cycles = 0;
        got = 1'b0;
        mem_checker_i.push_expected(port_d, !write, line_at(base + 10));
        if (port_d)
        begin
            mem_addr_d = tdata[base + 1];
            mem_wdata_d = line_at(base + 2);
            mem_read_d = !write;
            mem_write_d = write;
        end
        else
        begin
            mem_addr_i = tdata[base + 1];
            mem_read_i = 1'b1;
        end
        while (!got && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
            got = port_d ? mem_resp_d : mem_resp_i;
        end
        if (!got)
        begin
            $display("ERROR: transaction %0d got no response within %0d cycles", idx, TIMEOUT);
            timeouts++;
        end
        else if (timed && cycles != `PMEM_LATENCY + 1)
        begin
            $display("CHECK FAILED %s latency: expected 0x%0h cycles, got 0x%0h",
                port_d ? "mem_resp_d_o" : "mem_resp_i_o", `PMEM_LATENCY + 1, cycles);
            latency_errors++;
        end
        // drop in the cycle after the pulse.
        @(negedge clk);
        if (port_d)
        begin
            mem_read_d = 1'b0;
            mem_write_d = 1'b0;
        end
        else
        begin
            mem_read_i = 1'b0;
        end
    endtask

    initial
    begin
        int cycles;
        int gap;
        int errors;
        mem_read_i = 1'b0;
        mem_addr_i = '0;
        mem_read_d = 1'b0;
        mem_write_d = 1'b0;
        mem_addr_d = '0;
        mem_wdata_d = '0;
        contend = 1'b0;
        latency_errors = 0;
        timeouts = 0;
        void'($urandom(32013));
        $readmemh("testbench/mem_testdata.hex", tdata);

        cycles = 0;
        while (rst !== 1'b0 && cycles < 50)
        begin
            @(negedge clk);
            cycles++;
        end
        if (rst !== 1'b0)
        begin
            $display("ERROR: reset was never released");
            timeouts++;
        end

        // any response in this quiet period is unexpected.
        repeat (20) @(negedge clk);

        ////////////////////
        // isolated requests
        ////////////////////

        for (int t = 0; t < TXN_COUNT; t++)
        begin
            if (!tdata[t * TXN_WORDS][8])
            begin
                gap = int'($urandom % 4);
                repeat (gap) @(negedge clk);
                run_txn(t, 1'b1);
                @(negedge clk);
            end
            else if (tdata[t * TXN_WORDS][4])
            begin
                conc_d.push_back(t);
            end
            else
            begin
                conc_i.push_back(t);
            end
        end

        ////////////////////
        // both ports at once
        ////////////////////

        repeat (2) @(negedge clk);
        contend = 1'b1;
        @(negedge clk);
        fork
            begin
                foreach (conc_i[j])
                begin
                    run_txn(conc_i[j], 1'b0);
                    @(negedge clk);
                end
            end
            begin
                foreach (conc_d[j])
                begin
                    run_txn(conc_d[j], 1'b0);
                    @(negedge clk);
                end
            end
        join
        contend = 1'b0;
        repeat (3) @(negedge clk);

        errors = checker_errors + latency_errors;
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : tb_mem_subsys

`default_nettype wire

/* testbench/mem_testdata.hex */
// ctrl (bit 8 concurrent, bit 4 data port, bit 0 write), byte address,
// write line words 0..7, expected read line words 0..7
00000000 00000020 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000100 00000101 00000102 00000103 00000104 00000105 00000106 00000107
00000010 00000040 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000200 00000201 00000202 00000203 00000204 00000205 00000206 00000207
00000011 00000060 c0de3000 c0de3001 c0de3002 c0de3003 c0de3004 c0de3005 c0de3006 c0de3007 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000010 00000060 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 c0de3000 c0de3001 c0de3002 c0de3003 c0de3004 c0de3005 c0de3006 c0de3007
00000000 00000060 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 c0de3000 c0de3001 c0de3002 c0de3003 c0de3004 c0de3005 c0de3006 c0de3007
00000011 000007e0 beef3f00 beef3f01 beef3f02 beef3f03 beef3f04 beef3f05 beef3f06 beef3f07 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 000007e0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 beef3f00 beef3f01 beef3f02 beef3f03 beef3f04 beef3f05 beef3f06 beef3f07
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000001 00000002 00000003 00000004 00000005 00000006 00000007
00000100 000000a0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000500 00000501 00000502 00000503 00000504 00000505 00000506 00000507
00000110 00000140 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000a00 00000a01 00000a02 00000a03 00000a04 00000a05 00000a06 00000a07
00000100 00000060 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 c0de3000 c0de3001 c0de3002 c0de3003 c0de3004 c0de3005 c0de3006 c0de3007
00000111 00000280 feed1400 feed1401 feed1402 feed1403 feed1404 feed1405 feed1406 feed1407 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000100 000000c0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000600 00000601 00000602 00000603 00000604 00000605 00000606 00000607
00000110 00000280 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 feed1400 feed1401 feed1402 feed1403 feed1404 feed1405 feed1406 feed1407
00000100 000007e0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 beef3f00 beef3f01 beef3f02 beef3f03 beef3f04 beef3f05 beef3f06 beef3f07
00000110 000000e0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000700 00000701 00000702 00000703 00000704 00000705 00000706 00000707

/* tb.f */
+incdir+hw
hw/mem_arb_pkg.sv
hw/arbiter_control.sv
hw/arbiter_datapath.sv
hw/pmem_model.sv
hw/mem_subsys_top.sv
testbench/tb_clock_gen.sv
testbench/mem_checker.sv
testbench/tb_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys \
    -f tb.f -o sim_mem_subsys || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_mem_subsys)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
